// File: rtl/nx_consts.svh
// Stream width, header field positions, direction codes
// and the skid buffer setting for the mesh routing node

`ifndef NX_CONSTS_SVH
`define NX_CONSTS_SVH

// Message width on every stream
`define NX_STREAM_WIDTH 32

// Header fields
`define NX_BCAST_BIT 31
`define NX_ROW_HI    30
`define NX_ROW_LO    27
`define NX_COL_HI    26
`define NX_COL_LO    23

// Direction codes in clockwise order, so code + 1 is the next neighbour round
`define NX_DIR_NORTH 2'd0
`define NX_DIR_EAST  2'd1
`define NX_DIR_SOUTH 2'd2
`define NX_DIR_WEST  2'd3

// Skid buffers on the outbound neighbour streams
`define NX_SKID_BUFFERS "yes"

`endif

// File: rtl/nx_pkg.sv
// Types shared by the routing node RTL

`include "nx_consts.svh"

package nx_pkg;

// One message word
typedef logic [`NX_STREAM_WIDTH-1:0] stream_data_t;

// Row or column position in the mesh
typedef logic [3:0] coord_t;

// Neighbour direction, see NX_DIR_* codes
typedef logic [1:0] dir_t;

// Skid buffer fill level
typedef enum logic [1:0] {
    SKID_EMPTY,
    SKID_ONE,
    SKID_TWO
} skid_state_t;

endpackage : nx_pkg

// File: rtl/nx_route_if.sv
// Decoded message link from route decoder to stream distributor

interface nx_route_if import nx_pkg::*; ();

// Message and the neighbour it is headed for
stream_data_t data;
dir_t         dir;

// Handshake
logic         valid;
logic         ready;

// Decoder side
modport source (
      output data
    , output dir
    , output valid
    , input  ready
);

// Distributor side
modport sink (
      input  data
    , input  dir
    , input  valid
    , output ready
);

endinterface : nx_route_if

// File: rtl/nx_node_config.sv
// Node coordinate registers and configured flag

module nx_node_config import nx_pkg::*; (
      input  logic       clk_i
    , input  logic       reset_i
    // Single write strobe, row in high nibble, column in low nibble
    , input  logic       cfg_write_i
    , input  logic [7:0] cfg_data_i
    // Towards the decoder
    , output coord_t     node_row_o
    , output coord_t     node_col_o
    , output logic       configured_o
);

coord_t row_q;
coord_t col_q;
logic   configured_q;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        row_q        <= '0;
        col_q        <= '0;
        configured_q <= 1'b0;
    end else if (cfg_write_i) begin
        row_q        <= cfg_data_i[7:4];
        col_q        <= cfg_data_i[3:0];
        // Sticky until the next reset
        configured_q <= 1'b1;
    end
end

assign node_row_o   = row_q;
assign node_col_o   = col_q;
assign configured_o = configured_q;

endmodule : nx_node_config

// File: rtl/nx_stream_skid.sv
// Two-entry skid buffer for one valid/ready stream
// with the outbound side driven from registers only

module nx_stream_skid import nx_pkg::*; #(
      parameter STREAM_WIDTH = 32
) (
      input  logic         clk_i
    , input  logic         reset_i
    // Inbound stream
    , input  stream_data_t inbound_data_i
    , input  logic         inbound_valid_i
    , output logic         inbound_ready_o
    // Outbound stream
    , output stream_data_t outbound_data_o
    , output logic         outbound_valid_o
    , input  logic         outbound_ready_i
);

if (STREAM_WIDTH != $bits(stream_data_t)) begin : g_width_check
    $error("STREAM_WIDTH does not match stream_data_t");
end

skid_state_t  state;
// Head feeds the outbound port, tail catches the second message
stream_data_t head_q;
stream_data_t tail_q;
logic         push;
logic         pop;

assign outbound_valid_o = (state != SKID_EMPTY);
assign inbound_ready_o  = (state != SKID_TWO);
assign outbound_data_o  = head_q;

assign push = inbound_valid_i && inbound_ready_o;
assign pop  = outbound_valid_o && outbound_ready_i;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state <= SKID_EMPTY;
    end else begin
        case (state)
            SKID_EMPTY: if (push) state <= SKID_ONE;
            SKID_ONE: begin
                if (push && !pop) begin
                    state <= SKID_TWO;
                end else if (pop && !push) begin
                    state <= SKID_EMPTY;
                end
            end
            SKID_TWO: if (pop) state <= SKID_ONE;
            default: state <= SKID_EMPTY;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    case (state)
        SKID_EMPTY: if (push) head_q <= inbound_data_i;
        SKID_ONE: begin
            if (push && pop) begin
                head_q <= inbound_data_i;
            end else if (push) begin
                tail_q <= inbound_data_i;
            end
        end
        // Tail moves up as the head leaves
        SKID_TWO: if (pop) head_q <= tail_q;
        default: ;
    endcase
end

// Full buffer takes nothing in until its head leaves
no_push_when_full_a : assert property (@(posedge clk_i) disable iff (reset_i)
    state == SKID_TWO && !pop |=> state == SKID_TWO && $stable(head_q) && $stable(tail_q));

endmodule : nx_stream_skid

// File: rtl/nx_route_decoder.sv
// Inbound message register with column-first route decode
// and the local delivery output

`include "nx_consts.svh"

module nx_route_decoder import nx_pkg::*; (
      input  logic         clk_i
    , input  logic         reset_i
    // Inbound stream
    , input  stream_data_t in_data_i
    , input  logic         in_valid_i
    , output logic         in_ready_o
    // Node position
    , input  coord_t       node_row_i
    , input  coord_t       node_col_i
    , input  logic         configured_i
    // Decoded link to the distributor
    , nx_route_if.source   route
    // Local stream
    , output stream_data_t local_data_o
    , output logic         local_valid_o
    , input  logic         local_ready_i
);

coord_t       tgt_row;
coord_t       tgt_col;
dir_t         next_dir;
logic         next_local;

// Holding register
stream_data_t held_data;
dir_t         held_dir;
logic         held_local;
logic         held_valid;
logic         held_leave;
logic         accept;

assign tgt_row = in_data_i[`NX_ROW_HI:`NX_ROW_LO];
assign tgt_col = in_data_i[`NX_COL_HI:`NX_COL_LO];

// Column first, then row
always_comb begin
    next_local = 1'b0;
    if (tgt_col > node_col_i) begin
        next_dir = `NX_DIR_EAST;
    end else if (tgt_col < node_col_i) begin
        next_dir = `NX_DIR_WEST;
    end else if (tgt_row > node_row_i) begin
        next_dir = `NX_DIR_SOUTH;
    end else if (tgt_row < node_row_i) begin
        next_dir = `NX_DIR_NORTH;
    end else begin
        // Addressed to this node, dir unused
        next_dir   = `NX_DIR_NORTH;
        next_local = 1'b1;
    end
end

assign held_leave = held_valid && (held_local ? local_ready_i : route.ready);
assign in_ready_o = configured_i && (!held_valid || held_leave);
assign accept     = in_valid_i && in_ready_o;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        held_valid <= 1'b0;
    end else if (accept) begin
        held_valid <= 1'b1;
    end else if (held_leave) begin
        held_valid <= 1'b0;
    end
end

always_ff @(posedge clk_i) begin
    if (accept) begin
        held_data  <= in_data_i;
        held_dir   <= next_dir;
        held_local <= next_local;
    end
end

assign route.data  = held_data;
assign route.dir   = held_dir;
assign route.valid = held_valid && !held_local;

assign local_data_o  = held_data;
assign local_valid_o = held_valid && held_local;

// Stalled route message must not change under the distributor
route_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
    route.valid && !route.ready |=> route.valid && $stable(route.data) && $stable(route.dir));

endmodule : nx_route_decoder

// File: rtl/nx_stream_distributor.sv
// Fan-out of decoded messages to north, east, south and west,
// with clockwise rerouting round absent neighbours and broadcast drop

`include "nx_consts.svh"

module nx_stream_distributor import nx_pkg::*; #(
      parameter STREAM_WIDTH = 32
    , parameter SKID_BUFFERS = "no"
) (
      input  logic         clk_i
    , input  logic         reset_i
    // Decoded message link
    , nx_route_if.sink     route
    // North
    , output stream_data_t north_data_o
    , output logic         north_valid_o
    , input  logic         north_ready_i
    , input  logic         north_present_i
    // East
    , output stream_data_t east_data_o
    , output logic         east_valid_o
    , input  logic         east_ready_i
    , input  logic         east_present_i
    // South
    , output stream_data_t south_data_o
    , output logic         south_valid_o
    , input  logic         south_ready_i
    , input  logic         south_present_i
    // West
    , output stream_data_t west_data_o
    , output logic         west_valid_o
    , input  logic         west_ready_i
    , input  logic         west_present_i
);

// All per-direction vectors are indexed by direction code
logic [3:0]         present;
logic [3:0]         out_ready;
logic [3:0]         skid_valid;
logic [3:0]         skid_ready;
stream_data_t [3:0] out_data;
logic [3:0]         out_valid;

logic broadcast;
logic target_present;
dir_t alt_dir;

assign present   = {west_present_i, south_present_i, east_present_i, north_present_i};
assign out_ready = {west_ready_i, south_ready_i, east_ready_i, north_ready_i};

assign broadcast      = route.data[`NX_BCAST_BIT];
assign target_present = present[route.dir];
// Next neighbour clockwise, wraps west to north
assign alt_dir        = route.dir + 2'd1;

always_comb begin
    skid_valid = '0;
    if (route.valid) begin
        if (target_present) begin
            skid_valid[route.dir] = 1'b1;
        end else if (!broadcast) begin
            skid_valid[alt_dir] = 1'b1;
        end
    end
end

// Broadcast with nowhere to go is swallowed
assign route.ready = target_present ? skid_ready[route.dir]
                                    : (broadcast || skid_ready[alt_dir]);

for (genvar i = 0; i < 4; i++) begin : g_port
    if (SKID_BUFFERS == "yes") begin : g_skid
        nx_stream_skid #(
            .STREAM_WIDTH(STREAM_WIDTH)
        ) skid_inst (
              .clk_i           (clk_i)
            , .reset_i         (reset_i)
            , .inbound_data_i  (route.data)
            , .inbound_valid_i (skid_valid[i])
            , .inbound_ready_o (skid_ready[i])
            , .outbound_data_o (out_data[i])
            , .outbound_valid_o(out_valid[i])
            , .outbound_ready_i(out_ready[i])
        );
    end else begin : g_direct
        assign out_data[i]   = route.data;
        assign out_valid[i]  = skid_valid[i];
        assign skid_ready[i] = out_ready[i];
    end
end

assign north_data_o  = out_data[`NX_DIR_NORTH];
assign north_valid_o = out_valid[`NX_DIR_NORTH];
assign east_data_o   = out_data[`NX_DIR_EAST];
assign east_valid_o  = out_valid[`NX_DIR_EAST];
assign south_data_o  = out_data[`NX_DIR_SOUTH];
assign south_valid_o = out_valid[`NX_DIR_SOUTH];
assign west_data_o   = out_data[`NX_DIR_WEST];
assign west_valid_o  = out_valid[`NX_DIR_WEST];

// A stalled message keeps one and the same neighbour
one_target_a : assert property (@(posedge clk_i) disable iff (reset_i)
    route.valid && !route.ready |=> $onehot0(skid_valid) && $stable(skid_valid));

endmodule : nx_stream_distributor

// File: rtl/nx_node_router.sv
// Top level of one mesh routing node: config block, route decoder,
// distributor and the four neighbour skid buffers

`include "nx_consts.svh"

module nx_node_router import nx_pkg::*; (
      input  logic         clk_i
    , input  logic         reset_i
    // Configuration
    , input  logic         cfg_write_i
    , input  logic [7:0]   cfg_data_i
    // Inbound stream
    , input  stream_data_t in_data_i
    , input  logic         in_valid_i
    , output logic         in_ready_o
    // Local stream
    , output stream_data_t local_data_o
    , output logic         local_valid_o
    , input  logic         local_ready_i
    // North
    , output stream_data_t north_data_o
    , output logic         north_valid_o
    , input  logic         north_ready_i
    , input  logic         north_present_i
    // East
    , output stream_data_t east_data_o
    , output logic         east_valid_o
    , input  logic         east_ready_i
    , input  logic         east_present_i
    // South
    , output stream_data_t south_data_o
    , output logic         south_valid_o
    , input  logic         south_ready_i
    , input  logic         south_present_i
    // West
    , output stream_data_t west_data_o
    , output logic         west_valid_o
    , input  logic         west_ready_i
    , input  logic         west_present_i
);

coord_t node_row;
coord_t node_col;
logic   configured;

nx_route_if route_link ();

nx_node_config node_config_inst (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .cfg_write_i (cfg_write_i)
    , .cfg_data_i  (cfg_data_i)
    , .node_row_o  (node_row)
    , .node_col_o  (node_col)
    , .configured_o(configured)
);

nx_route_decoder route_decoder_inst (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .in_data_i    (in_data_i)
    , .in_valid_i   (in_valid_i)
    , .in_ready_o   (in_ready_o)
    , .node_row_i   (node_row)
    , .node_col_i   (node_col)
    , .configured_i (configured)
    , .route        (route_link.source)
    , .local_data_o (local_data_o)
    , .local_valid_o(local_valid_o)
    , .local_ready_i(local_ready_i)
);

nx_stream_distributor #(
      .STREAM_WIDTH(`NX_STREAM_WIDTH)
    , .SKID_BUFFERS(`NX_SKID_BUFFERS)
) stream_distributor_inst (
      .clk_i          (clk_i)
    , .reset_i        (reset_i)
    , .route          (route_link.sink)
    , .north_data_o   (north_data_o)
    , .north_valid_o  (north_valid_o)
    , .north_ready_i  (north_ready_i)
    , .north_present_i(north_present_i)
    , .east_data_o    (east_data_o)
    , .east_valid_o   (east_valid_o)
    , .east_ready_i   (east_ready_i)
    , .east_present_i (east_present_i)
    , .south_data_o   (south_data_o)
    , .south_valid_o  (south_valid_o)
    , .south_ready_i  (south_ready_i)
    , .south_present_i(south_present_i)
    , .west_data_o    (west_data_o)
    , .west_valid_o   (west_valid_o)
    , .west_ready_i   (west_ready_i)
    , .west_present_i (west_present_i)
);

endmodule : nx_node_router

// File: tests/tb_nx_node_router.sv
// Directed testbench for the mesh routing node with reset and config,
// routing, latency, rerouting, broadcast drop and back-pressure tests

`include "nx_consts.svh"

module tb_nx_node_router import nx_pkg::*; ();

localparam int PERIOD       = 40;
localparam int RESET_CYCLES = 10;
localparam int ROUTE_ROUNDS = 2;
localparam int BP_COUNT     = 5;
// Routing, latency, rerouting, broadcast and back-pressure messages
localparam int TOTAL_MSGS   = 5 * ROUTE_ROUNDS + 2 + 2 + 2 + BP_COUNT;
localparam int MSG_CYCLES   = 20;
localparam int DRAIN_CYCLES = 30;
localparam int NODE_ROW     = 5;
localparam int NODE_COL     = 5;
localparam int LOCAL_PORT   = 4;

logic         clk_i;
logic         reset_i;
logic         cfg_write_i;
logic [7:0]   cfg_data_i;
stream_data_t in_data_i;
logic         in_valid_i;
logic         in_ready_o;
stream_data_t local_data_o, north_data_o, east_data_o, south_data_o, west_data_o;
logic         local_valid_o, north_valid_o, east_valid_o, south_valid_o, west_valid_o;
logic         local_ready_i, north_ready_i, east_ready_i, south_ready_i, west_ready_i;
logic         north_present_i, east_present_i, south_present_i, west_present_i;

// Port index 0 to 3 follows the direction code, 4 is local
logic [4:0]   ready_mask;
logic [3:0]   present_mask;
logic [4:0]   out_valid;
stream_data_t out_data [0:4];
stream_data_t expect_q [0:4][$];
int           due_q [0:4][$];
string        port_name [0:4] = '{"north_data_o", "east_data_o", "south_data_o",
                                  "west_data_o", "local_data_o"};
int           cycle_count = 0;
int           checks = 0;
int           value_errors = 0;
int           other_errors = 0;
logic [31:0]  rng_state = 32'd85080;

assign {local_ready_i, west_ready_i, south_ready_i, east_ready_i, north_ready_i} = ready_mask;
assign {west_present_i, south_present_i, east_present_i, north_present_i} = present_mask;
assign out_valid = {local_valid_o, west_valid_o, south_valid_o, east_valid_o, north_valid_o};
assign out_data[0] = north_data_o;
assign out_data[1] = east_data_o;
assign out_data[2] = south_data_o;
assign out_data[3] = west_data_o;
assign out_data[4] = local_data_o;

nx_node_router nx_node_router_inst (.*);

always #(PERIOD / 2) clk_i = ~clk_i;

function automatic logic [31:0] xorshift32(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Header plus a random 23-bit payload
function automatic stream_data_t make_msg(input logic bcast, input int row, input int col);
    rng_state = xorshift32(rng_state);
    return {bcast, row[3:0], col[3:0], rng_state[22:0]};
endfunction

// Column first, then row, then clockwise detour round an absent neighbour
function automatic int predict_port(input stream_data_t msg);
    int row;
    int col;
    int dir;
    row = int'(msg[`NX_ROW_HI:`NX_ROW_LO]);
    col = int'(msg[`NX_COL_HI:`NX_COL_LO]);
    if (col > NODE_COL) begin
        dir = `NX_DIR_EAST;
    end else if (col < NODE_COL) begin
        dir = `NX_DIR_WEST;
    end else if (row > NODE_ROW) begin
        dir = `NX_DIR_SOUTH;
    end else if (row < NODE_ROW) begin
        dir = `NX_DIR_NORTH;
    end else begin
        return LOCAL_PORT;
    end
    if (present_mask[dir]) begin
        return dir;
    end
    // Dropped broadcast
    if (msg[`NX_BCAST_BIT]) begin
        return -1;
    end
    return (dir + 1) % 4;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
        value_errors++;
        $display("error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

// Called on a falling edge and returns on the falling edge after the transfer
task automatic send_msg(input stream_data_t msg, input bit timed);
    int port;
    port = predict_port(msg);
    in_data_i  = msg;
    in_valid_i = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) begin
        @(posedge clk_i);
    end
    if (port >= 0) begin
        expect_q[port].push_back(msg);
        due_q[port].push_back(timed ? cycle_count + (port == LOCAL_PORT ? 1 : 2) : 0);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
endtask

task automatic wait_drained();
    int pending;
    for (int c = 0; c < DRAIN_CYCLES; c++) begin
        pending = 0;
        for (int p = 0; p < 5; p++) begin
            pending += expect_q[p].size();
        end
        if (pending == 0) begin
            break;
        end
        @(negedge clk_i);
    end
    // Idle gap so that stray or repeated messages reach the monitor
    repeat (4) @(negedge clk_i);
    for (int p = 0; p < 5; p++) begin
        checks++;
        assert (expect_q[p].size() == 0) else begin
            other_errors++;
            $display("%0d message(s) never arrived on %s", expect_q[p].size(), port_name[p]);
            expect_q[p].delete();
            due_q[p].delete();
        end
    end
endtask

// Output monitor checking order per port and optional arrival cycle
always @(posedge clk_i) begin
    int due;
    cycle_count <= cycle_count + 1;
    for (int p = 0; p < 5; p++) begin
        if (!reset_i && out_valid[p] && ready_mask[p]) begin
            checks++;
            assert (expect_q[p].size() > 0) else begin
                other_errors++;
                $display("Unexpected message %h on %s at time %0t",
                         out_data[p], port_name[p], $time);
            end
            if (expect_q[p].size() > 0) begin
                due = due_q[p].pop_front();
                check_value(port_name[p], expect_q[p].pop_front(), out_data[p]);
                if (due != 0) begin
                    check_value({port_name[p], " arrival cycle"}, 32'(due), 32'(cycle_count));
                end
            end
        end
    end
end

task automatic reset_and_configure();
    repeat (RESET_CYCLES) begin
        @(negedge clk_i);
        check_value("in_ready_o", 0, 32'(in_ready_o));
        check_value("valid outputs", 0, 32'(out_valid));
    end
    reset_i = 1'b0;
    repeat (3) begin
        @(negedge clk_i);
        check_value("in_ready_o", 0, 32'(in_ready_o));
        check_value("valid outputs", 0, 32'(out_valid));
    end
    cfg_write_i = 1'b1;
    cfg_data_i  = 8'((NODE_ROW << 4) | NODE_COL);
    check_value("in_ready_o", 0, 32'(in_ready_o));
    @(negedge clk_i);
    cfg_write_i = 1'b0;
    check_value("in_ready_o", 1, 32'(in_ready_o));
endtask

task automatic route_by_address();
    repeat (ROUTE_ROUNDS) begin
        send_msg(make_msg(1'b0, NODE_ROW, NODE_COL + 3), 1'b0);
        send_msg(make_msg(1'b0, NODE_ROW + 2, NODE_COL - 2), 1'b0);
        send_msg(make_msg(1'b0, NODE_ROW + 1, NODE_COL), 1'b0);
        send_msg(make_msg(1'b0, NODE_ROW - 4, NODE_COL), 1'b0);
        send_msg(make_msg(1'b0, NODE_ROW, NODE_COL), 1'b0);
    end
    wait_drained();
endtask

task automatic measure_latency();
    send_msg(make_msg(1'b0, NODE_ROW - 1, NODE_COL + 1), 1'b1);
    send_msg(make_msg(1'b0, NODE_ROW, NODE_COL), 1'b1);
    wait_drained();
endtask

task automatic reroute_absent();
    // East absent sends east traffic south
    present_mask = 4'b1101;
    send_msg(make_msg(1'b0, NODE_ROW, NODE_COL + 1), 1'b0);
    wait_drained();
    // West absent wraps round to north
    present_mask = 4'b0111;
    send_msg(make_msg(1'b0, NODE_ROW, NODE_COL - 1), 1'b0);
    wait_drained();
    present_mask = 4'b1111;
endtask

task automatic drop_broadcast();
    present_mask = 4'b1101;
    send_msg(make_msg(1'b1, NODE_ROW, NODE_COL + 2), 1'b0);
    wait_drained();
    present_mask = 4'b1111;
    send_msg(make_msg(1'b1, NODE_ROW, NODE_COL + 2), 1'b0);
    wait_drained();
endtask

task automatic stall_north();
    bit dropped;
    ready_mask[0] = 1'b0;
    // Decoder register and both skid entries fill up
    for (int i = 0; i < 3; i++) begin
        send_msg(make_msg(1'b0, i % NODE_ROW, NODE_COL), 1'b0);
    end
    dropped = 1'b0;
    for (int c = 0; c < 8 && !dropped; c++) begin
        @(negedge clk_i);
        dropped = !in_ready_o;
    end
    checks++;
    assert (dropped) else begin
        other_errors++;
        $display("in_ready_o stayed high with north ready held low");
    end
    ready_mask[0] = 1'b1;
    for (int i = 3; i < BP_COUNT; i++) begin
        send_msg(make_msg(1'b0, i % NODE_ROW, NODE_COL), 1'b0);
    end
    wait_drained();
endtask

initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    cfg_write_i  = 1'b0;
    cfg_data_i   = '0;
    in_data_i    = '0;
    in_valid_i   = 1'b0;
    ready_mask   = '1;
    present_mask = '1;
    reset_and_configure();
    route_by_address();
    measure_latency();
    reroute_absent();
    drop_broadcast();
    stall_north();
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

// Watchdog
initial begin
    #((RESET_CYCLES + 8 * (DRAIN_CYCLES + 4) + TOTAL_MSGS * MSG_CYCLES) * PERIOD);
    $display("Watchdog expired before the tests finished, value errors: %0d, other errors: %0d",
             value_errors, other_errors);
    $display("Simulation failed");
    $finish;
end

endmodule : tb_nx_node_router

// File: nx_node_router.f
+incdir+rtl
rtl/nx_pkg.sv
rtl/nx_route_if.sv
rtl/nx_node_config.sv
rtl/nx_stream_skid.sv
rtl/nx_route_decoder.sv
rtl/nx_stream_distributor.sv
rtl/nx_node_router.sv
tests/tb_nx_node_router.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_nx_node_router
RTL_TOP   = nx_node_router
FILELIST  = nx_node_router.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
